// File: include/prc_cfg.svh
`ifndef PRC_CFG_SVH
`define PRC_CFG_SVH

// Bus widths
`define PRC_ADDR_W 24
`define PRC_DATA_W 8

// Memory map
`define PRC_VRAM_BASE    24'h001000  // 96 x 8 pages frame buffer
`define PRC_TILEMAP_BASE 24'h001360  // Tile index map
`define PRC_LCD_CMD      24'h0020FE
`define PRC_LCD_DATA     24'h0020FF
`define PRC_REG_BASE     24'h002080  // Stage control is the first register

// Screen geometry
`define PRC_COLS  96
`define PRC_PAGES 8  // 8-row pages

// LCD command bytes
`define PRC_LCD_COL_HI 8'h10
`define PRC_LCD_COL_LO 8'h00
`define PRC_LCD_PAGE   8'hB0  // Page number goes in the low bits

`endif

// File: rtl/prc_regs_pkg.sv
`include "prc_cfg.svh"

package prc_regs_pkg;

    // CPU visible registers with a hole at 2081h
    typedef enum logic [`PRC_ADDR_W-1:0] {
        REG_STAGE_CTRL   = `PRC_REG_BASE,
        REG_MAP_BASE_LO  = `PRC_REG_BASE + 24'd2,
        REG_MAP_BASE_MID = `PRC_REG_BASE + 24'd3,
        REG_MAP_BASE_HI  = `PRC_REG_BASE + 24'd4,
        REG_SCROLL_Y     = `PRC_REG_BASE + 24'd5,
        REG_SCROLL_X     = `PRC_REG_BASE + 24'd6
    } prc_reg_addr_e;

    // Map size field as width x height in tiles
    typedef enum logic [1:0] {
        MAP_12X16 = 2'd0,
        MAP_16X12 = 2'd1,
        MAP_24X8  = 2'd2,
        MAP_24X16 = 2'd3
    } prc_map_size_e;

    function automatic logic [4:0] prc_map_width(prc_map_size_e size);
        case (size)
            MAP_12X16: return 5'd12;
            MAP_16X12: return 5'd16;
            default:   return 5'd24;
        endcase
    endfunction

    function automatic logic [4:0] prc_map_height(prc_map_size_e size);
        case (size)
            MAP_16X12: return 5'd12;
            MAP_24X8:  return 5'd8;
            default:   return 5'd16;
        endcase
    endfunction

endpackage

// File: rtl/prc_seq_pkg.sv
package prc_seq_pkg;

    // Frame pass stages
    typedef enum logic [1:0] {
        IDLE,
        MAP_DRAW,
        FRAME_COPY
    } prc_stage_e;

    // Five bus accesses per video column
    typedef enum logic [2:0] {
        TILE_TOP,   // Tile index above the column
        TILE_BOT,
        DATA_TOP,   // Tile pixel bytes
        DATA_BOT,
        WRITE       // Composed byte into video RAM
    } prc_map_step_e;

    // LCD page setup followed by column transfers
    typedef enum logic [2:0] {
        COL_HI,
        COL_LO,
        PAGE,
        MEM_READ,
        LCD_WRITE
    } prc_copy_step_e;

endpackage

// File: rtl/prc_regs.sv
`timescale 1ns/1ps
`include "prc_cfg.svh"

module prc_regs
    import prc_regs_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_cyc,
    input  logic                   cfg_stb,
    input  logic                   cfg_we,
    input  logic [`PRC_ADDR_W-1:0] cfg_adr,
    input  logic [`PRC_DATA_W-1:0] cfg_dat_w,
    output logic [`PRC_DATA_W-1:0] cfg_dat_r,
    output logic                   cfg_ack,
    input  logic                   busy,
    output logic                   start,
    output logic                   map_en,
    output logic                   copy_en,
    output prc_map_size_e          map_size,
    output logic [`PRC_ADDR_W-1:0] map_base,
    output logic [6:0]             scroll_x,
    output logic [6:0]             scroll_y
);

    logic [5:0] stage_ctrl;
    logic [4:0] base_lo;    // Bits 7:3 of the tile base
    logic [7:0] base_mid;
    logic [4:0] base_hi;    // Bits 20:16
    logic       new_req;
    logic [7:0] lim_x;
    logic [7:0] lim_y;

    assign new_req = cfg_cyc && cfg_stb && !cfg_ack;

    // Largest scroll that keeps the 96x64 window inside the map
    assign lim_x = {prc_map_width(map_size), 3'b000} - 8'd96;
    assign lim_y = {prc_map_height(map_size), 3'b000} - 8'd64;

    assign map_en   = stage_ctrl[1];
    assign copy_en  = stage_ctrl[3];
    assign map_size = prc_map_size_e'(stage_ctrl[5:4]);
    assign map_base = {3'b000, base_hi, base_mid, base_lo, 3'b000};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg_ack    <= 1'b0;
            start      <= 1'b0;
            stage_ctrl <= '0;
            base_lo    <= '0;
            base_mid   <= '0;
            base_hi    <= '0;
            scroll_x   <= '0;
            scroll_y   <= '0;
        end
        else
        begin
            cfg_ack <= new_req;  // Single cycle ack
            start   <= 1'b0;
            if (new_req && cfg_we)
            begin
                case (prc_reg_addr_e'(cfg_adr))
                    REG_STAGE_CTRL:
                    begin
                        stage_ctrl <= cfg_dat_w[5:0];
                        start      <= (cfg_dat_w[1] || cfg_dat_w[3]) && !busy;
                    end
                    REG_MAP_BASE_LO:  base_lo  <= cfg_dat_w[7:3];
                    REG_MAP_BASE_MID: base_mid <= cfg_dat_w;
                    REG_MAP_BASE_HI:  base_hi  <= cfg_dat_w[4:0];
                    REG_SCROLL_Y:
                        if (cfg_dat_w <= lim_y)
                            scroll_y <= cfg_dat_w[6:0];
                    REG_SCROLL_X:
                        if (cfg_dat_w <= lim_x)
                            scroll_x <= cfg_dat_w[6:0];
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    always_comb
    begin
        case (prc_reg_addr_e'(cfg_adr))
            REG_STAGE_CTRL:   cfg_dat_r = {2'b00, stage_ctrl};
            REG_MAP_BASE_LO:  cfg_dat_r = {base_lo, 3'b000};
            REG_MAP_BASE_MID: cfg_dat_r = base_mid;
            REG_MAP_BASE_HI:  cfg_dat_r = {3'b000, base_hi};
            REG_SCROLL_Y:     cfg_dat_r = {1'b0, scroll_y};
            REG_SCROLL_X:     cfg_dat_r = {1'b0, scroll_x};
            default:          cfg_dat_r = '0;
        endcase
    end

endmodule

// File: rtl/prc_map_draw.sv
`timescale 1ns/1ps
`include "prc_cfg.svh"

module prc_map_draw
    import prc_regs_pkg::*;
    import prc_seq_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   go,
    input  prc_map_size_e          map_size,
    input  logic [`PRC_ADDR_W-1:0] map_base,
    input  logic [6:0]             scroll_x,
    input  logic [6:0]             scroll_y,
    output logic                   acc_req,
    output logic                   acc_we,
    output logic [`PRC_ADDR_W-1:0] acc_adr,
    output logic [`PRC_DATA_W-1:0] acc_wdat,
    input  logic [`PRC_DATA_W-1:0] acc_rdat,
    input  logic                   acc_done,
    output logic                   fin
);

    prc_map_step_e step;
    logic          active;
    logic [2:0]    page_idx;
    logic [6:0]    col_idx;
    logic [7:0]    top_idx;
    logic [7:0]    bot_idx;
    logic [7:0]    top_data;
    logic [7:0]    bot_data;
    logic [4:0]    width;
    logic [7:0]    map_x;
    logic [7:0]    map_y;
    logic [2:0]    shift;
    logic [9:0]    tile_off;
    logic [9:0]    vram_off;
    logic          last_col;
    logic          last_page;

    assign width    = prc_map_width(map_size);
    assign map_x    = {1'b0, col_idx} + {1'b0, scroll_x};
    assign map_y    = {2'b00, page_idx, 3'b000} + {1'b0, scroll_y};
    assign shift    = map_y[2:0];  // Row offset inside the tile
    assign tile_off = 10'(map_y[7:3]) * 10'(width) + 10'(map_x[7:3]);
    assign vram_off = 10'(page_idx) * 10'(`PRC_COLS) + 10'(col_idx);

    assign last_col  = col_idx == 7'(`PRC_COLS - 1);
    assign last_page = page_idx == 3'(`PRC_PAGES - 1);

    assign acc_req = active;
    assign acc_we  = step == WRITE;
    assign fin     = active && acc_done && step == WRITE && last_col && last_page;

    // Column straddles two tile rows unless the scroll is tile aligned
    assign acc_wdat = (shift == 3'd0) ? top_data :
                      (top_data >> shift) | (bot_data << (4'd8 - {1'b0, shift}));

    always_comb
    begin
        case (step)
            TILE_TOP: acc_adr = `PRC_TILEMAP_BASE + {14'd0, tile_off};
            TILE_BOT: acc_adr = `PRC_TILEMAP_BASE + {14'd0, tile_off} + {19'd0, width};
            DATA_TOP: acc_adr = map_base + {13'd0, top_idx, map_x[2:0]};
            DATA_BOT: acc_adr = map_base + {13'd0, bot_idx, map_x[2:0]};
            default:  acc_adr = `PRC_VRAM_BASE + {14'd0, vram_off};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active   <= 1'b0;
            step     <= TILE_TOP;
            page_idx <= '0;
            col_idx  <= '0;
        end
        else if (go)
        begin
            active   <= 1'b1;
            step     <= TILE_TOP;
            page_idx <= '0;
            col_idx  <= '0;
        end
        else if (active && acc_done)
        begin
            case (step)
                TILE_TOP: step <= TILE_BOT;
                TILE_BOT: step <= DATA_TOP;
                DATA_TOP: step <= DATA_BOT;
                DATA_BOT: step <= WRITE;
                default:
                begin
                    step <= TILE_TOP;
                    if (last_col)
                    begin
                        col_idx <= '0;
                        if (last_page)
                            active <= 1'b0;  // Whole screen done
                        else
                            page_idx <= page_idx + 3'd1;
                    end
                    else
                        col_idx <= col_idx + 7'd1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (active && acc_done)
        begin
            case (step)
                TILE_TOP: top_idx  <= acc_rdat;
                TILE_BOT: bot_idx  <= acc_rdat;
                DATA_TOP: top_data <= acc_rdat;
                DATA_BOT: bot_data <= acc_rdat;
                default:
                begin
                end
            endcase
        end
    end

endmodule

// File: rtl/prc_frame_copy.sv
`timescale 1ns/1ps
`include "prc_cfg.svh"

module prc_frame_copy
    import prc_seq_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   go,
    output logic                   acc_req,
    output logic                   acc_we,
    output logic [`PRC_ADDR_W-1:0] acc_adr,
    output logic [`PRC_DATA_W-1:0] acc_wdat,
    input  logic [`PRC_DATA_W-1:0] acc_rdat,
    input  logic                   acc_done,
    output logic                   fin
);

    prc_copy_step_e step;
    logic           active;
    logic [2:0]     page_idx;
    logic [6:0]     col_idx;
    logic [7:0]     pix;       // Video byte on its way to the LCD
    logic [9:0]     vram_off;
    logic           last_col;
    logic           last_page;

    assign vram_off  = 10'(page_idx) * 10'(`PRC_COLS) + 10'(col_idx);
    assign last_col  = col_idx == 7'(`PRC_COLS - 1);
    assign last_page = page_idx == 3'(`PRC_PAGES - 1);

    assign acc_req = active;
    assign acc_we  = step != MEM_READ;
    assign fin     = active && acc_done && step == LCD_WRITE && last_col && last_page;

    always_comb
    begin
        acc_adr  = `PRC_LCD_CMD;
        acc_wdat = '0;
        case (step)
            COL_HI:    acc_wdat = `PRC_LCD_COL_HI;
            COL_LO:    acc_wdat = `PRC_LCD_COL_LO;
            PAGE:      acc_wdat = `PRC_LCD_PAGE | {5'd0, page_idx};
            MEM_READ:  acc_adr  = `PRC_VRAM_BASE + {14'd0, vram_off};
            default:
            begin
                acc_adr  = `PRC_LCD_DATA;
                acc_wdat = pix;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active   <= 1'b0;
            step     <= COL_HI;
            page_idx <= '0;
            col_idx  <= '0;
        end
        else if (go)
        begin
            active   <= 1'b1;
            step     <= COL_HI;
            page_idx <= '0;
            col_idx  <= '0;
        end
        else if (active && acc_done)
        begin
            case (step)
                COL_HI:   step <= COL_LO;
                COL_LO:   step <= PAGE;
                PAGE:     step <= MEM_READ;
                MEM_READ: step <= LCD_WRITE;
                default:
                begin
                    step <= MEM_READ;
                    if (last_col)
                    begin
                        col_idx <= '0;
                        step    <= COL_HI;  // Next page needs its own setup
                        if (last_page)
                            active <= 1'b0;
                        else
                            page_idx <= page_idx + 3'd1;
                    end
                    else
                        col_idx <= col_idx + 7'd1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (active && acc_done && step == MEM_READ)
            pix <= acc_rdat;
    end

endmodule

// File: rtl/prc_sequencer.sv
`timescale 1ns/1ps
`include "prc_cfg.svh"

module prc_sequencer
    import prc_seq_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   map_en,
    input  logic                   copy_en,
    output logic                   busy,
    output logic                   map_go,
    output logic                   copy_go,
    input  logic                   map_fin,
    input  logic                   copy_fin,
    input  logic                   map_req,
    input  logic                   map_we,
    input  logic [`PRC_ADDR_W-1:0] map_adr,
    input  logic [`PRC_DATA_W-1:0] map_wdat,
    input  logic                   copy_req,
    input  logic                   copy_we,
    input  logic [`PRC_ADDR_W-1:0] copy_adr,
    input  logic [`PRC_DATA_W-1:0] copy_wdat,
    output logic [`PRC_DATA_W-1:0] acc_rdat,
    output logic                   map_done,
    output logic                   copy_done,
    output logic                   mem_cyc,
    output logic                   mem_stb,
    output logic                   mem_we,
    output logic [`PRC_ADDR_W-1:0] mem_adr,
    output logic [`PRC_DATA_W-1:0] mem_dat_w,
    input  logic [`PRC_DATA_W-1:0] mem_dat_r,
    input  logic                   mem_ack,
    output logic                   irq_render_done,
    output logic                   irq_copy_complete
);

    prc_stage_e             stage;
    logic                   copy_pend;  // Copy stage follows the map stage
    logic                   sel_req;
    logic                   sel_we;
    logic [`PRC_ADDR_W-1:0] sel_adr;
    logic [`PRC_DATA_W-1:0] sel_wdat;
    logic                   acc_done;

    assign busy      = (stage != IDLE) || start;
    assign acc_done  = mem_cyc && mem_ack;
    assign map_done  = acc_done && stage == MAP_DRAW;
    assign copy_done = acc_done && stage == FRAME_COPY;
    assign acc_rdat  = mem_dat_r;
    assign mem_stb   = mem_cyc;  // Strobe follows cyc in single beat cycles

    // Only the engine of the current stage reaches the bus
    always_comb
    begin
        sel_req  = 1'b0;
        sel_we   = map_we;
        sel_adr  = map_adr;
        sel_wdat = map_wdat;
        case (stage)
            MAP_DRAW:   sel_req = map_req;
            FRAME_COPY:
            begin
                sel_req  = copy_req;
                sel_we   = copy_we;
                sel_adr  = copy_adr;
                sel_wdat = copy_wdat;
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            mem_cyc <= 1'b0;
        else if (mem_cyc)
            mem_cyc <= !mem_ack;  // Hold until ack, then drop for a cycle
        else
            mem_cyc <= sel_req;
    end

    always_ff @(posedge clk)
    begin
        if (!mem_cyc && sel_req)
        begin
            mem_we    <= sel_we;
            mem_adr   <= sel_adr;
            mem_dat_w <= sel_wdat;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage             <= IDLE;
            copy_pend         <= 1'b0;
            map_go            <= 1'b0;
            copy_go           <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
        end
        else
        begin
            map_go            <= 1'b0;
            copy_go           <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
            case (stage)
                IDLE:
                    if (start)
                    begin
                        copy_pend <= copy_en;
                        if (map_en)
                        begin
                            stage  <= MAP_DRAW;
                            map_go <= 1'b1;
                        end
                        else if (copy_en)
                        begin
                            stage   <= FRAME_COPY;
                            copy_go <= 1'b1;
                        end
                    end
                MAP_DRAW:
                    if (map_fin)
                    begin
                        if (copy_pend)
                        begin
                            stage   <= FRAME_COPY;
                            copy_go <= 1'b1;
                        end
                        else
                        begin
                            stage           <= IDLE;
                            irq_render_done <= 1'b1;
                        end
                    end
                FRAME_COPY:
                    if (copy_fin)
                    begin
                        stage             <= IDLE;
                        irq_render_done   <= 1'b1;
                        irq_copy_complete <= 1'b1;
                    end
                default: stage <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/prc_top.sv
`timescale 1ns/1ps
`include "prc_cfg.svh"

module prc_top
    import prc_regs_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_cyc,
    input  logic                   cfg_stb,
    input  logic                   cfg_we,
    input  logic [`PRC_ADDR_W-1:0] cfg_adr,
    input  logic [`PRC_DATA_W-1:0] cfg_dat_w,
    output logic [`PRC_DATA_W-1:0] cfg_dat_r,
    output logic                   cfg_ack,
    output logic                   mem_cyc,
    output logic                   mem_stb,
    output logic                   mem_we,
    output logic [`PRC_ADDR_W-1:0] mem_adr,
    output logic [`PRC_DATA_W-1:0] mem_dat_w,
    input  logic [`PRC_DATA_W-1:0] mem_dat_r,
    input  logic                   mem_ack,
    output logic                   irq_render_done,
    output logic                   irq_copy_complete
);

    // Register block to sequencer and map engine
    logic                   busy;
    logic                   start;
    logic                   map_en;
    logic                   copy_en;
    prc_map_size_e          map_size;
    logic [`PRC_ADDR_W-1:0] map_base;
    logic [6:0]             scroll_x;
    logic [6:0]             scroll_y;

    // Engine handshakes
    logic                   map_go;
    logic                   copy_go;
    logic                   map_fin;
    logic                   copy_fin;
    logic                   map_req;
    logic                   map_we;
    logic [`PRC_ADDR_W-1:0] map_adr;
    logic [`PRC_DATA_W-1:0] map_wdat;
    logic                   copy_req;
    logic                   copy_we;
    logic [`PRC_ADDR_W-1:0] copy_adr;
    logic [`PRC_DATA_W-1:0] copy_wdat;
    logic [`PRC_DATA_W-1:0] acc_rdat;
    logic                   map_done;
    logic                   copy_done;

    prc_regs u_regs (
        .clk, .reset,
        .cfg_cyc, .cfg_stb, .cfg_we, .cfg_adr, .cfg_dat_w, .cfg_dat_r, .cfg_ack,
        .busy, .start, .map_en, .copy_en, .map_size, .map_base, .scroll_x, .scroll_y
    );

    prc_sequencer u_seq (
        .clk, .reset, .start, .map_en, .copy_en, .busy,
        .map_go, .copy_go, .map_fin, .copy_fin,
        .map_req, .map_we, .map_adr, .map_wdat,
        .copy_req, .copy_we, .copy_adr, .copy_wdat,
        .acc_rdat, .map_done, .copy_done,
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_dat_r, .mem_ack,
        .irq_render_done, .irq_copy_complete
    );

    prc_map_draw u_map (
        .clk, .reset,
        .go       (map_go),
        .map_size, .map_base, .scroll_x, .scroll_y,
        .acc_req  (map_req),
        .acc_we   (map_we),
        .acc_adr  (map_adr),
        .acc_wdat (map_wdat),
        .acc_rdat,
        .acc_done (map_done),
        .fin      (map_fin)
    );

    prc_frame_copy u_copy (
        .clk, .reset,
        .go       (copy_go),
        .acc_req  (copy_req),
        .acc_we   (copy_we),
        .acc_adr  (copy_adr),
        .acc_wdat (copy_wdat),
        .acc_rdat,
        .acc_done (copy_done),
        .fin      (copy_fin)
    );

endmodule

// File: testbench/prc_asserts.sv
`timescale 1ns/1ps
`include "prc_cfg.svh"

module prc_asserts (
    input logic                   clk,
    input logic                   reset,
    input logic                   mem_cyc,
    input logic                   mem_stb,
    input logic                   mem_we,
    input logic [`PRC_ADDR_W-1:0] mem_adr,
    input logic [`PRC_DATA_W-1:0] mem_dat_w,
    input logic                   mem_ack,
    input logic                   cfg_stb,
    input logic                   cfg_ack,
    input logic                   irq_render_done,
    input logic                   irq_copy_complete
);

    int fail_count = 0;

    stb_in_cyc: assert property (@(posedge clk) disable iff (reset) mem_stb |-> mem_cyc)
        else
        begin
            fail_count++;
            $error("mem_stb high without mem_cyc");
        end

    // Master holds the request until the slave acks
    master_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_stb && !mem_ack) |=> mem_stb && $stable(mem_adr) && $stable(mem_we)
                                  && $stable(mem_dat_w))
        else
        begin
            fail_count++;
            $error("Master signals changed while waiting for mem_ack");
        end

    ack_after_stb: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_stb))
        else
        begin
            fail_count++;
            $error("cfg_ack rose without cfg_stb");
        end

    render_pulse: assert property (@(posedge clk) disable iff (reset)
        irq_render_done |=> !irq_render_done)
        else
        begin
            fail_count++;
            $error("irq_render_done longer than one cycle");
        end

    copy_pulse: assert property (@(posedge clk) disable iff (reset)
        irq_copy_complete |=> !irq_copy_complete)
        else
        begin
            fail_count++;
            $error("irq_copy_complete longer than one cycle");
        end

endmodule

bind prc_top prc_asserts u_asserts (.*);

// File: testbench/prc_tb.sv
`timescale 1ns/1ps
`include "prc_cfg.svh"

module prc_tb;

    localparam int NUM_ROWS   = 5;
    localparam int VRAM_SIZE  = `PRC_COLS * `PRC_PAGES;
    localparam int MAX_CYCLES = NUM_ROWS * (3840 + 1560) * 6 + 2000;

    typedef struct {
        logic [1:0] size;
        logic [7:0] base_lo;
        logic [7:0] base_mid;
        logic [7:0] base_hi;
        logic [7:0] sy_a;
        logic [7:0] sy_b;
        logic [7:0] sy_exp;
        logic [7:0] sx_a;
        logic [7:0] sx_b;
        logic [7:0] sx_exp;
        logic [7:0] stage;
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   cfg_cyc;
    logic                   cfg_stb;
    logic                   cfg_we;
    logic [`PRC_ADDR_W-1:0] cfg_adr;
    logic [`PRC_DATA_W-1:0] cfg_dat_w;
    logic [`PRC_DATA_W-1:0] cfg_dat_r;
    logic                   cfg_ack;
    logic                   mem_cyc;
    logic                   mem_stb;
    logic                   mem_we;
    logic [`PRC_ADDR_W-1:0] mem_adr;
    logic [`PRC_DATA_W-1:0] mem_dat_w;
    logic [`PRC_DATA_W-1:0] mem_dat_r = '0;
    logic                   mem_ack = 1'b0;
    logic                   irq_render_done;
    logic                   irq_copy_complete;

    logic [7:0] mem [0:8191];             // 0000h to 1FFFh
    logic [7:0] exp_vram [0:VRAM_SIZE-1];
    logic [7:0] cmd_q [$];
    logic [7:0] data_q [$];
    row_t       rows [NUM_ROWS];
    integer     seed = 32'h0a5f_d721;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         render_cnt = 0;
    int         copy_cnt = 0;
    logic       bus_ok = 1'b0;  // A pass may use the bus
    logic       waiting = 1'b0;
    int         wait_left = 0;

    prc_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT never finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic serve_access();
        if (mem_we && mem_adr == `PRC_LCD_CMD)
            cmd_q.push_back(mem_dat_w);
        else if (mem_we && mem_adr == `PRC_LCD_DATA)
            data_q.push_back(mem_dat_w);
        else if (mem_adr < 24'h002000 && mem_we)
            mem[mem_adr[12:0]] = mem_dat_w;
        else if (mem_adr < 24'h002000)
            mem_dat_r = mem[mem_adr[12:0]];
        else
        begin
            errors++;
            $display("Bus access outside the memory model at %06h", mem_adr);
        end
    endtask

    // Memory and LCD model with random wait states
    always @(negedge clk)
    begin
        if (reset)
        begin
            mem_ack = 1'b0;
            waiting = 1'b0;
        end
        else if (mem_ack)
            mem_ack = 1'b0;
        else if (mem_cyc && mem_stb)
        begin
            if (!waiting)
            begin
                waiting   = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0)
            begin
                waiting = 1'b0;
                mem_ack = 1'b1;
                serve_access();
            end
            else
                wait_left--;
        end
    end

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (irq_render_done)
                render_cnt++;
            if (irq_copy_complete)
                copy_cnt++;
            if (mem_cyc && !bus_ok)
            begin
                errors++;
                $display("Bus cycle at %0t although no pass was started", $time);
            end
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("mismatch time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, exp, got);
        end
    endtask

    task automatic write_reg(input logic [23:0] adr, input logic [7:0] dat);
        @(negedge clk);
        cfg_cyc   = 1'b1;
        cfg_stb   = 1'b1;
        cfg_we    = 1'b1;
        cfg_adr   = adr;
        cfg_dat_w = dat;
        @(negedge clk);
        while (!cfg_ack)
            @(negedge clk);
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
        cfg_we  = 1'b0;
    endtask

    task automatic expect_reg(input logic [23:0] adr, input logic [7:0] exp, input string name);
        logic [7:0] rd;
        @(negedge clk);
        cfg_cyc = 1'b1;
        cfg_stb = 1'b1;
        cfg_we  = 1'b0;
        cfg_adr = adr;
        @(negedge clk);
        while (!cfg_ack)
            @(negedge clk);
        rd      = cfg_dat_r;  // Valid while ack is high
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
        check_value(name, rd, exp);
    endtask

    function automatic int tiles_wide(input logic [1:0] size);
        case (size)
            2'd0:    return 12;
            2'd1:    return 16;
            default: return 24;
        endcase
    endfunction

    // Expected video byte for one page and column
    function automatic logic [7:0] compose_byte(input int page, input int col, input int width,
                                                input int base, input int sx, input int sy);
        int          mx;
        int          my;
        int          tadr;
        int          s;
        logic [15:0] td;
        logic [15:0] bd;
        logic [15:0] res;
        mx   = col + sx;
        my   = 8 * page + sy;
        tadr = `PRC_TILEMAP_BASE + (my / 8) * width + mx / 8;
        td   = mem[base + 8 * mem[tadr] + mx % 8];
        bd   = mem[base + 8 * mem[tadr + width] + mx % 8];
        s    = my % 8;
        if (s == 0)
            return td[7:0];
        res = (td >> s) | (bd << (8 - s));
        return res[7:0];
    endfunction

    task automatic run_row(input int r);
        row_t row;
        int   base;
        int   width;
        int   i;
        row   = rows[r];
        width = tiles_wide(row.size);
        base  = {row.base_hi[4:0], row.base_mid, row.base_lo[7:3], 3'b000};

        // Bits 0 and 2 alone must not start a pass
        write_reg(`PRC_REG_BASE, {2'b11, row.size, 4'b0101});
        expect_reg(`PRC_REG_BASE, {2'b00, row.size, 4'b0101}, "stage_ctrl");
        write_reg(`PRC_REG_BASE + 1, 8'hFF);
        expect_reg(`PRC_REG_BASE + 1, 8'h00, "reg_2081");
        expect_reg(`PRC_REG_BASE + 7, 8'h00, "reg_2087");
        write_reg(`PRC_REG_BASE + 2, row.base_lo);
        write_reg(`PRC_REG_BASE + 3, row.base_mid);
        write_reg(`PRC_REG_BASE + 4, row.base_hi);
        expect_reg(`PRC_REG_BASE + 2, row.base_lo & 8'hF8, "map_base_lo");
        expect_reg(`PRC_REG_BASE + 3, row.base_mid, "map_base_mid");
        expect_reg(`PRC_REG_BASE + 4, row.base_hi & 8'h1F, "map_base_hi");
        write_reg(`PRC_REG_BASE + 5, row.sy_a);
        write_reg(`PRC_REG_BASE + 5, row.sy_b);
        write_reg(`PRC_REG_BASE + 6, row.sx_a);
        write_reg(`PRC_REG_BASE + 6, row.sx_b);
        expect_reg(`PRC_REG_BASE + 5, row.sy_exp, "scroll_y");
        expect_reg(`PRC_REG_BASE + 6, row.sx_exp, "scroll_x");

        if (row.stage[1])
            for (i = 0; i < VRAM_SIZE; i++)
                exp_vram[i] = compose_byte(i / `PRC_COLS, i % `PRC_COLS, width, base,
                                           row.sx_exp, row.sy_exp);

        cmd_q.delete();
        data_q.delete();
        render_cnt = 0;
        copy_cnt   = 0;
        bus_ok     = 1'b1;
        write_reg(`PRC_REG_BASE, row.stage);
        while (render_cnt == 0)
            @(negedge clk);
        repeat (4) @(negedge clk);  // Room for a stray second pulse
        bus_ok = 1'b0;

        check_value("irq_render_done count", render_cnt, 1);
        check_value("irq_copy_complete count", copy_cnt, row.stage[3]);
        if (row.stage[1])
            for (i = 0; i < VRAM_SIZE; i++)
                check_value($sformatf("vram[%0d]", i), mem[`PRC_VRAM_BASE + i], exp_vram[i]);
        check_value("lcd command count", cmd_q.size(), row.stage[3] ? 3 * `PRC_PAGES : 0);
        check_value("lcd data count", data_q.size(), row.stage[3] ? VRAM_SIZE : 0);
        if (row.stage[3] && cmd_q.size() == 3 * `PRC_PAGES && data_q.size() == VRAM_SIZE)
        begin
            for (i = 0; i < `PRC_PAGES; i++)
            begin
                check_value($sformatf("lcd_cmd[%0d]", 3 * i), cmd_q[3 * i], 8'h10);
                check_value($sformatf("lcd_cmd[%0d]", 3 * i + 1), cmd_q[3 * i + 1], 8'h00);
                check_value($sformatf("lcd_cmd[%0d]", 3 * i + 2), cmd_q[3 * i + 2], 8'hB0 + i);
            end
            for (i = 0; i < VRAM_SIZE; i++)
                check_value($sformatf("lcd_data[%0d]", i), data_q[i], exp_vram[i]);
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        cfg_cyc   = 1'b0;
        cfg_stb   = 1'b0;
        cfg_we    = 1'b0;
        cfg_adr   = '0;
        cfg_dat_w = '0;

        for (int a = 0; a < 8192; a++)
        begin
            mem[a] = 8'($random(seed));
            if (a >= 'h1360 && a < 'h1500)
                mem[a] = mem[a] & 8'h3F;  // Tile data stays below 1000h
        end
        for (int i = 0; i < VRAM_SIZE; i++)
            exp_vram[i] = mem[`PRC_VRAM_BASE + i];

        // size, base lo/mid/hi, scroll y a/b/readback, scroll x a/b/readback, stage
        rows[0] = '{2'd0, 8'h5F, 8'h02, 8'hE0, 8'd20, 8'd65, 8'd20, 8'd0, 8'd1, 8'd0, 8'h0A};
        rows[1] = '{2'd1, 8'h3C, 8'h05, 8'h00, 8'd33, 8'd13, 8'd13, 8'd32, 8'd33, 8'd32, 8'h13};
        rows[2] = '{2'd2, 8'h80, 8'h08, 8'h20, 8'd0, 8'd1, 8'd0, 8'd96, 8'd97, 8'd96, 8'h2E};
        rows[3] = '{2'd3, 8'hF7, 8'h0C, 8'h00, 8'd64, 8'd7, 8'd7, 8'd5, 8'd200, 8'd5, 8'h3A};
        rows[4] = '{2'd0, 8'h10, 8'h01, 8'h00, 8'd64, 8'd65, 8'd64, 8'd0, 8'd0, 8'd0, 8'h08};

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("mem_cyc", mem_cyc, 0);
        check_value("mem_stb", mem_stb, 0);
        check_value("cfg_ack", cfg_ack, 0);
        check_value("irq_render_done", irq_render_done, 0);
        check_value("irq_copy_complete", irq_copy_complete, 0);

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        check_value("bus assertion failures", u_dut.u_asserts.fail_count, 0);
        $display("Run finished with %0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: prc_top.f
+incdir+include
rtl/prc_regs_pkg.sv
rtl/prc_seq_pkg.sv
rtl/prc_regs.sv
rtl/prc_map_draw.sv
rtl/prc_frame_copy.sv
rtl/prc_sequencer.sv
rtl/prc_top.sv
testbench/prc_asserts.sv
testbench/prc_tb.sv
